//--- common/bus_cycle_if.sv
`timescale 1ns/100ps
`include "msx_map_settings.svh"

// One decoded CPU cycle, valid for a single clk42m
interface bus_cycle_if
	import msx_map_pkg::*;
();
	logic						valid;		// One pulse per CPU cycle
	cycle_kind_e				kind;
	msx_addr_u					addr;
	slot_sel_t					slot;		// Slot of the addressed page
	msx_byte_t					wdata;
	logic [`MSX_SEG_W-1:0]		segment;	// Mapper segment of the page
	msx_byte_t					reg_rdata;	// Register readback value

	// Producer side
	modport decode (
		output valid, kind, addr, slot, wdata, segment, reg_rdata
	);

	// Consumers, SDRAM map and read latch
	modport user (
		input valid, kind, addr, slot, wdata, segment, reg_rdata
	);

endinterface

//--- common/msx_map_pkg.sv
`include "msx_map_settings.svh"

package msx_map_pkg;

	// --------------------------------------------------------------------
	// Basic words
	// --------------------------------------------------------------------
	typedef logic [`MSX_DATA_W-1:0]			msx_byte_t;
	typedef logic [`MSX_SDRAM_ADDR_W-1:0]	sdram_addr_t;

	// CPU address word
	// Memory cycles look at the 16KB page, I/O cycles at the low byte
	typedef struct packed {
		logic [1:0]					page;		// A15..A14
		logic [`MSX_ADDR_W-3:0]		offset;		// A13..A0
	} msx_mem_addr_t;

	typedef struct packed {
		logic [`MSX_ADDR_W-9:0]		high;		// B or A register, don't care
		logic [7:0]					port;		// Port number
	} msx_io_addr_t;

	typedef union packed {
		msx_mem_addr_t	mem;
		msx_io_addr_t	io;
	} msx_addr_u;

	// --------------------------------------------------------------------
	// Decoded cycle
	// --------------------------------------------------------------------
	typedef enum logic [2:0] {
		CYC_NONE	= 3'd0,		// Ignored I/O port
		CYC_MEM_RD	= 3'd1,
		CYC_MEM_WR	= 3'd2,
		CYC_REG_RD	= 3'd3,		// Slot or mapper register readback
		CYC_REG_WR	= 3'd4
	} cycle_kind_e;

	// Resolved slot of a memory page
	typedef struct packed {
		logic [1:0]	pri;		// Primary slot
		logic [1:0]	sec;		// Secondary slot, 0 when not expanded
	} slot_sel_t;

endpackage

//--- common/msx_map_settings.svh
`ifndef MSX_MAP_SETTINGS_SVH
`define MSX_MAP_SETTINGS_SVH

// --------------------------------------------------------------------
// CPU bus
// --------------------------------------------------------------------
`define MSX_ADDR_W			16		// Z80 address bus
`define MSX_DATA_W			8		// Z80 data bus

// SDRAM byte address, 8MB space
`define MSX_SDRAM_ADDR_W	23

// --------------------------------------------------------------------
// I/O ports and special addresses
// --------------------------------------------------------------------
`define MSX_PORT_SLOT		8'hA8		// Primary slot register
`define MSX_PORT_MAPPER		8'hFC		// Mapper segments, FCh..FFh
`define MSX_SUBSLOT_ADDR	16'hFFFF	// Secondary slot register

// --------------------------------------------------------------------
// Memory mapper
// --------------------------------------------------------------------
`define MSX_SEG_W			8		// 256 segments of 16KB

// Power-on segments, page 0 gets the highest one
`define MSX_RESET_SEG0		3
`define MSX_RESET_SEG1		2
`define MSX_RESET_SEG2		1
`define MSX_RESET_SEG3		0

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the MSX map testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module msx_map_tb -Mdir "$OBJ" -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vmsx_map_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
echo "Simulation passed"
exit 0

//--- sim/msx_map_checker.sv
`timescale 1ns/100ps

module msx_map_checker
	import msx_map_pkg::*;
(
	input	logic			clk42m,
	input	logic			ff_reset_n,
	input	logic			sdram_req,
	input	logic			sdram_ack,
	input	logic			sdram_we,
	input	sdram_addr_t	sdram_addr
);
	// ----------------------------------------------------------------------
	// Four-phase SDRAM handshake
	// ----------------------------------------------------------------------
	req_hold_a: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		sdram_req && !sdram_ack |=> sdram_req)
		else $error("sdram_req dropped before sdram_ack");

	// Address and direction frozen until ack
	addr_stable_a: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		sdram_req && !sdram_ack |=> $stable(sdram_addr) && $stable(sdram_we))
		else $error("sdram_addr or sdram_we changed while waiting for ack");

	no_rise_a: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!sdram_req && sdram_ack |=> !sdram_req)		// Old ack still high
		else $error("sdram_req raised while sdram_ack was high");

endmodule

bind msx_map_top msx_map_checker msx_map_checker_i (
	.clk42m			( clk42m		),
	.ff_reset_n		( ff_reset_n	),
	.sdram_req		( sdram_req		),
	.sdram_ack		( sdram_ack		),
	.sdram_we		( sdram_we		),
	.sdram_addr		( sdram_addr	)
);

//--- sim/msx_map_tb.sv
`timescale 1ns/100ps
`include "msx_map_settings.svh"

module msx_map_tb
	import msx_map_pkg::*;
();
	localparam int TIMEOUT = 64;		// Cycles allowed per wait loop

	logic						clk42m;
	logic						ff_reset_n;
	logic [`MSX_ADDR_W-1:0]		addr;
	msx_byte_t					wdata;
	logic						mreq_n;
	logic						iorq_n;
	logic						rd_n;
	logic						wr_n;
	msx_byte_t					cpu_rdata;
	logic						cpu_wait_n;
	logic						sdram_req;
	logic						sdram_we;
	sdram_addr_t				sdram_addr;
	msx_byte_t					sdram_wdata;
	logic						sdram_ack;
	msx_byte_t					sdram_rdata;

	// Own copies of the slot and mapper registers
	msx_byte_t					model_prim;
	msx_byte_t					model_sub0;
	msx_byte_t					model_sub3;
	msx_byte_t					model_seg [4];

	msx_byte_t					sdram_mem [sdram_addr_t];	// Written bytes only

	// Expected request of the running CPU cycle
	string						exp_name;
	logic						exp_mapped;
	sdram_addr_t				exp_addr;
	logic						exp_we;
	msx_byte_t					exp_wdata;
	int							req_seen;
	logic						req_prev;

	int							checks;
	int							mismatches;
	int							failures;
	int							ack_delay;
	int							ack_wait;
	int							ack_hold;

	msx_map_top msx_map_top_i (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.addr			( addr			),
		.wdata			( wdata			),
		.mreq_n			( mreq_n		),
		.iorq_n			( iorq_n		),
		.rd_n			( rd_n			),
		.wr_n			( wr_n			),
		.cpu_rdata		( cpu_rdata		),
		.cpu_wait_n		( cpu_wait_n	),
		.sdram_req		( sdram_req		),
		.sdram_we		( sdram_we		),
		.sdram_addr		( sdram_addr	),
		.sdram_wdata	( sdram_wdata	),
		.sdram_ack		( sdram_ack		),
		.sdram_rdata	( sdram_rdata	)
	);

	always #2 clk42m = ~clk42m;		// 4 ns period

	// ----------------------------------------------------------------------
	// Compare tasks and reference model
	// ----------------------------------------------------------------------
	task automatic check_addr(input string name, input sdram_addr_t exp, input sdram_addr_t act);
		checks++;
		if (exp !== act) begin
			mismatches++;
			$display("MISMATCH %s expected %06h actual %06h", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input msx_byte_t exp, input msx_byte_t act);
		checks++;
		if (exp !== act) begin
			mismatches++;
			$display("MISMATCH %s expected %02h actual %02h", name, exp, act);
		end
	endtask

	task automatic note_failure(input string name, input string what);
		failures++;
		$display("%s: %s", name, what);
	endtask

	// Unwritten SDRAM bytes depend on every address bit
	function automatic msx_byte_t hash_byte(input sdram_addr_t a);
		return a[7:0] ^ a[15:8] ^ {a[22:16], 1'b1} ^ 8'h3C;
	endfunction

	function automatic msx_byte_t model_byte(input sdram_addr_t a);
		if (sdram_mem.exists(a)) begin
			return sdram_mem[a];
		end
		return hash_byte(a);
	endfunction

	// Expected SDRAM address of a memory cycle and whether it is mapped
	function automatic logic ref_map(input msx_byte_t prim, input msx_byte_t sub0,
			input msx_byte_t sub3, input msx_byte_t seg, input logic [15:0] a,
			input logic wr, output sdram_addr_t ea);
		logic [1:0]		page;
		logic [1:0]		pri;
		logic [1:0]		sec;
		logic [9:0]		up;
		logic			hit;
		int				sh;

		page	= a[15:14];
		sh		= 2 * page;
		pri		= prim[sh +: 2];
		sec		= (pri == 2'd0) ? sub0[sh +: 2] : (pri == 2'd3) ? sub3[sh +: 2] : 2'd0;
		hit		= 1'b0;
		up		= '0;
		if ({pri, sec} == 4'hC) begin		// 3-0 mapper RAM
			hit	= 1'b1;
			up	= 10'h200 | {1'b0, seg, a[13]};
		end
		else if (!wr) begin
			case ({pri, sec})
			4'h3: begin
				hit	= (page == 2'd1) || (page == 2'd2);
				up	= 10'h01C | 10'(a[14:13]);
			end
			4'h2: begin
				hit	= (page == 2'd1);
				up	= 10'h00C | 10'(a[13]);
			end
			4'h1: begin
				hit	= (page == 2'd1);
				up	= 10'h008 | 10'(a[13]);
			end
			4'hD: begin
				hit	= 1'b1;
				up	= (page == 2'd0) ? (10'h020 | 10'(a[13])) : (10'h014 | 10'({a[15], a[13]}));
			end
			4'h0: begin
				hit	= (page < 2'd2);
				up	= 10'h010 | 10'(a[14:13]);
			end
			4'hE: begin
				hit	= (page == 2'd1) || (page == 2'd2);
				up	= 10'(a[15:13]);
			end
			default: hit = 1'b0;
			endcase
		end
		ea = {up, a[12:0]};
		return hit;
	endfunction

	function automatic logic [15:0] random_addr();
		logic [31:0]	r;

		r = $urandom;
		if (r[15:0] == `MSX_SUBSLOT_ADDR) begin
			r[0] = 1'b0;		// FFFFh is a register in slots 0 and 3
		end
		return r[15:0];
	endfunction

	// ----------------------------------------------------------------------
	// CPU model
	// ----------------------------------------------------------------------
	task automatic start_cycle(input logic io, input logic wr, input logic [15:0] a,
			input msx_byte_t d);
		@(negedge clk42m);
		addr	= a;
		wdata	= d;
		mreq_n	= io;
		iorq_n	= !io;
		rd_n	= wr;
		wr_n	= !wr;
	endtask

	task automatic end_cycle();
		mreq_n		= 1'b1;
		iorq_n		= 1'b1;
		rd_n		= 1'b1;
		wr_n		= 1'b1;
		exp_mapped	= 1'b0;
		repeat (2) @(negedge clk42m);
	endtask

	// Register data is on cpu_rdata two cycles after the strobe
	task automatic reg_read(input logic io, input logic [15:0] a, input string name,
			input msx_byte_t exp);
		exp_name = name;
		start_cycle(io, 1'b0, a, 8'h00);
		repeat (2) @(negedge clk42m);
		check_byte(name, exp, cpu_rdata);
		end_cycle();
		check_byte({name, " release"}, 8'hFF, cpu_rdata);
	endtask

	task automatic reg_write(input logic io, input logic [15:0] a, input msx_byte_t d);
		exp_name = "register write";
		start_cycle(io, 1'b1, a, d);
		repeat (2) @(negedge clk42m);
		end_cycle();
	endtask

	task automatic write_slot(input msx_byte_t v);
		reg_write(1'b1, {8'($urandom), `MSX_PORT_SLOT}, v);
		model_prim = v;
	endtask

	task automatic write_seg(input int idx, input msx_byte_t v);
		reg_write(1'b1, {8'($urandom), 8'(`MSX_PORT_MAPPER + idx)}, v);
		model_seg[idx] = v;
	endtask

	// Lands in the register of the page-3 slot when it is 0 or 3
	task automatic write_subslot(input msx_byte_t v);
		reg_write(1'b0, `MSX_SUBSLOT_ADDR, v);
		if (model_prim[7:6] == 2'd0) begin
			model_sub0 = v;
		end
		else if (model_prim[7:6] == 2'd3) begin
			model_sub3 = v;
		end
	endtask

	task automatic randomize_slots();
		write_slot({2'd0, 6'($urandom)});
		write_subslot(msx_byte_t'($urandom));
		write_slot({2'd3, 6'($urandom)});
		write_subslot(msx_byte_t'($urandom));
		write_slot(msx_byte_t'($urandom));
	endtask

	task automatic mem_access(input string name, input logic wr, input logic [15:0] a,
			input msx_byte_t d, output msx_byte_t rd);
		sdram_addr_t	ea;
		logic			mapped;
		int				n;

		mapped		= ref_map(model_prim, model_sub0, model_sub3, model_seg[a[15:14]], a, wr, ea);
		exp_name	= name;
		exp_addr	= ea;
		exp_we		= wr;
		exp_wdata	= d;
		exp_mapped	= mapped;
		req_seen	= 0;
		rd			= 8'hFF;
		start_cycle(1'b0, wr, a, d);
		if (mapped) begin
			n = 0;
			while (cpu_wait_n && n < TIMEOUT) begin
				@(negedge clk42m);
				n++;
			end
			if (cpu_wait_n) begin
				note_failure(name, "cpu_wait_n never went low for a mapped cycle");
			end
			n = 0;
			while (!cpu_wait_n && n < TIMEOUT) begin
				@(negedge clk42m);
				n++;
			end
			if (!cpu_wait_n) begin
				note_failure(name, "timeout, cpu_wait_n stayed low");
			end
			@(negedge clk42m);		// Latch follows the wait release
			if (req_seen != 1) begin
				note_failure(name, "expected exactly one SDRAM request");
			end
		end
		else begin
			repeat (4) @(negedge clk42m);
			if (!cpu_wait_n) begin
				note_failure(name, "CPU held in wait on an unmapped cycle");
			end
		end
		if (!wr) begin
			rd = cpu_rdata;
			check_byte(name, mapped ? model_byte(ea) : 8'hFF, cpu_rdata);
		end
		end_cycle();
		if (!wr) begin
			check_byte({name, " release"}, 8'hFF, cpu_rdata);
		end
	endtask

	// ----------------------------------------------------------------------
	// SDRAM model with random ack latency
	// ----------------------------------------------------------------------
	always begin
		@(negedge clk42m);
		if (ff_reset_n && sdram_req && !sdram_ack) begin
			ack_delay = $urandom % 5 + 1;
			repeat (ack_delay - 1) @(negedge clk42m);
			if (sdram_we) begin
				sdram_mem[sdram_addr] = sdram_wdata;
			end
			else begin
				sdram_rdata = model_byte(sdram_addr);
			end
			sdram_ack	= 1'b1;
			ack_wait	= 0;
			while (sdram_req && ack_wait < TIMEOUT) begin
				@(negedge clk42m);
				ack_wait++;
			end
			if (sdram_req) begin
				note_failure("sdram model", "sdram_req not dropped after ack");
			end
			// Late ack release lets the next CPU cycle queue behind it
			ack_hold = $urandom % 12;
			repeat (ack_hold) @(negedge clk42m);
			sdram_ack = 1'b0;
		end
	end

	// Each new request against the reference map
	always @(negedge clk42m) begin
		if (ff_reset_n && sdram_req && !req_prev) begin
			req_seen++;
			if (!exp_mapped) begin
				note_failure(exp_name, "SDRAM request raised for an unmapped cycle");
			end
			else begin
				check_addr(exp_name, exp_addr, sdram_addr);
				if (sdram_we !== exp_we) begin
					note_failure(exp_name, "sdram_we has the wrong direction");
				end
				if (exp_we) begin
					check_byte({exp_name, " wdata"}, exp_wdata, sdram_wdata);
				end
			end
		end
		if (ff_reset_n && sdram_req && cpu_wait_n) begin
			note_failure(exp_name, "cpu_wait_n high while a request is pending");
		end
		req_prev = sdram_req;
	end

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		int							i;
		msx_byte_t					v;
		msx_byte_t					v0;
		msx_byte_t					v3;
		msx_byte_t					rd;
		logic [`MSX_ADDR_W-1:0]		a;

		void'($urandom(38917));
		clk42m			= 1'b0;
		ff_reset_n		= 1'b0;
		addr			= '0;
		wdata			= '0;
		mreq_n			= 1'b1;
		iorq_n			= 1'b1;
		rd_n			= 1'b1;
		wr_n			= 1'b1;
		sdram_ack		= 1'b0;
		sdram_rdata		= '0;
		req_prev		= 1'b0;
		exp_mapped		= 1'b0;
		exp_name		= "reset";
		checks			= 0;
		mismatches		= 0;
		failures		= 0;
		model_prim		= 8'h00;
		model_sub0		= 8'h00;
		model_sub3		= 8'h00;
		model_seg[0]	= msx_byte_t'(`MSX_RESET_SEG0);
		model_seg[1]	= msx_byte_t'(`MSX_RESET_SEG1);
		model_seg[2]	= msx_byte_t'(`MSX_RESET_SEG2);
		model_seg[3]	= msx_byte_t'(`MSX_RESET_SEG3);
		repeat (2) @(negedge clk42m);		// Two reset cycles
		ff_reset_n = 1'b1;
		@(negedge clk42m);

		// Reset values and primary slot readback
		check_byte("reset cpu_rdata", 8'hFF, cpu_rdata);
		if (sdram_req !== 1'b0 || cpu_wait_n !== 1'b1) begin
			note_failure("reset", "SDRAM request or CPU wait active after reset");
		end
		reg_read(1'b1, {8'h00, `MSX_PORT_SLOT}, "reset slot", 8'h00);
		for (i = 0; i < 4; i++) begin
			reg_read(1'b1, {8'h00, 8'(`MSX_PORT_MAPPER + i)}, "reset segment", model_seg[i]);
		end
		for (i = 0; i < 8; i++) begin
			write_slot(msx_byte_t'($urandom));
			reg_read(1'b1, {8'($urandom), `MSX_PORT_SLOT}, "slot readback", model_prim);
		end

		// Secondary registers read back inverted and kept apart
		v0 = $urandom;
		v3 = $urandom;
		write_slot(8'h00);
		write_subslot(v0);
		reg_read(1'b0, `MSX_SUBSLOT_ADDR, "subslot 0", ~v0);
		write_slot(8'hC0);
		write_subslot(v3);
		reg_read(1'b0, `MSX_SUBSLOT_ADDR, "subslot 3", ~v3);
		write_slot(8'h00);
		reg_read(1'b0, `MSX_SUBSLOT_ADDR, "subslot 0 kept", ~v0);

		// Random slots and reads against the reference map
		for (i = 0; i < 24; i++) begin
			randomize_slots();
			repeat (4) begin
				mem_access("random read", 1'b0, random_addr(), 8'h00, rd);
			end
		end

		// Mapper RAM on every page in slot 3-0
		write_slot(8'hFF);
		write_subslot(8'h00);
		for (i = 0; i < 4; i++) begin
			write_seg(i, msx_byte_t'($urandom));
		end
		for (i = 0; i < 4; i++) begin
			a			= random_addr();
			a[15:14]	= i[1:0];
			a[0]		= 1'b0;
			v			= $urandom;
			mem_access("mapper write", 1'b1, a, v, rd);
			mem_access("mapper read", 1'b0, a, 8'h00, rd);
			check_byte("mapper readback", v, rd);
			v0 = model_seg[i];
			write_seg(i, v0 ^ 8'h55);		// Other segment holds other data
			mem_access("mapper redirect", 1'b0, a, 8'h00, rd);
			write_seg(i, v0);
			mem_access("mapper restore", 1'b0, a, 8'h00, rd);
			check_byte("mapper restore", v, rd);
		end
		for (i = 0; i < 4; i++) begin
			reg_read(1'b1, {8'($urandom), 8'(`MSX_PORT_MAPPER + i)}, "segment readback",
					model_seg[i]);
		end

		// ROM writes raise no request
		write_slot(8'h00);
		write_subslot(8'h00);
		mem_access("rom write", 1'b1, 16'h1234, 8'hA5, rd);
		for (i = 0; i < 12; i++) begin
			randomize_slots();
			mem_access("random write", 1'b1, random_addr(), msx_byte_t'($urandom), rd);
		end

		// Main ROM reads under random ack delay
		write_slot(8'h00);
		write_subslot(8'h00);
		for (i = 0; i < 16; i++) begin
			a		= random_addr();
			a[15]	= 1'b0;
			mem_access("main rom read", 1'b0, a, 8'h00, rd);
		end

		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("NO ERRORS");
		end
		else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- slot_decode/slot_decode.sv
`timescale 1ns/100ps
`include "msx_map_settings.svh"

module slot_decode
	import msx_map_pkg::*;
(
	input	logic				clk42m,
	input	logic				ff_reset_n,
	input	msx_addr_u			addr,
	input	msx_byte_t			wdata,
	input	logic				mreq_n,
	input	logic				iorq_n,
	input	logic				rd_n,
	input	logic				wr_n,
	bus_cycle_if.decode			cyc
);
	logic						ff_rd_n_d;		// Previous strobe levels
	logic						ff_wr_n_d;
	logic						ff_busy;		// Cycle already classified
	logic [7:0]					ff_prim_slot;	// Port A8h, 2 bits per page
	logic [7:0]					ff_sub0;		// Expanded slot 0
	logic [7:0]					ff_sub3;		// Expanded slot 3
	logic [`MSX_SEG_W-1:0]		ff_seg [4];		// Ports FCh..FFh

	logic						w_strobe;
	logic						w_is_rd;
	logic						w_port_slot;
	logic						w_port_mapper;
	logic						w_subslot_hit;
	logic [1:0]					w_page;
	logic [1:0]					w_pri;
	logic [1:0]					w_sec;
	cycle_kind_e				w_kind;
	msx_byte_t					w_reg_rdata;

	// --------------------------------------------------------------------
	// Slot resolution
	// --------------------------------------------------------------------
	assign w_page	= addr.mem.page;
	assign w_pri	= ff_prim_slot[{w_page, 1'b0} +: 2];
	assign w_sec	= (w_pri == 2'd0) ? ff_sub0[{w_page, 1'b0} +: 2] :
					  (w_pri == 2'd3) ? ff_sub3[{w_page, 1'b0} +: 2] : 2'd0;

	// Falling rd_n or wr_n inside mreq or iorq, once per cycle
	assign w_strobe	= !ff_busy && (!mreq_n || !iorq_n) &&
					  ((ff_rd_n_d && !rd_n) || (ff_wr_n_d && !wr_n));
	assign w_is_rd	= !rd_n;

	assign w_port_slot		= !iorq_n && (addr.io.port == `MSX_PORT_SLOT);
	assign w_port_mapper	= !iorq_n && ({addr.io.port[7:2], 2'b00} == `MSX_PORT_MAPPER);
	// FFFFh is page 3, so w_pri is the page-3 slot here
	assign w_subslot_hit	= !mreq_n && (addr == `MSX_SUBSLOT_ADDR) &&
							  (w_pri == 2'd0 || w_pri == 2'd3);

	always_comb begin
		w_kind		= CYC_NONE;
		w_reg_rdata	= '1;
		if (w_port_slot) begin
			w_kind		= w_is_rd ? CYC_REG_RD : CYC_REG_WR;
			w_reg_rdata	= ff_prim_slot;
		end
		else if (w_port_mapper) begin
			w_kind		= w_is_rd ? CYC_REG_RD : CYC_REG_WR;
			w_reg_rdata	= msx_byte_t'(ff_seg[addr.io.port[1:0]]);
		end
		else if (w_subslot_hit) begin
			w_kind		= w_is_rd ? CYC_REG_RD : CYC_REG_WR;
			w_reg_rdata	= (w_pri == 2'd0) ? ~ff_sub0 : ~ff_sub3;	// Read back inverted
		end
		else if (!mreq_n) begin
			w_kind		= w_is_rd ? CYC_MEM_RD : CYC_MEM_WR;
		end
	end

	// --------------------------------------------------------------------
	// Control and registers
	// --------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rd_n_d		<= 1'b1;
			ff_wr_n_d		<= 1'b1;
			ff_busy			<= 1'b0;
			ff_prim_slot	<= 8'h00;
			ff_sub0			<= 8'h00;
			ff_sub3			<= 8'h00;
			ff_seg[0]		<= `MSX_SEG_W'(`MSX_RESET_SEG0);
			ff_seg[1]		<= `MSX_SEG_W'(`MSX_RESET_SEG1);
			ff_seg[2]		<= `MSX_SEG_W'(`MSX_RESET_SEG2);
			ff_seg[3]		<= `MSX_SEG_W'(`MSX_RESET_SEG3);
			cyc.valid		<= 1'b0;
			cyc.kind		<= CYC_NONE;
		end
		else begin
			ff_rd_n_d	<= rd_n;
			ff_wr_n_d	<= wr_n;
			cyc.valid	<= w_strobe;
			if (w_strobe) begin
				ff_busy		<= 1'b1;
				cyc.kind	<= w_kind;
			end
			else if (rd_n && wr_n) begin
				ff_busy		<= 1'b0;		// End of CPU cycle
			end

			if (w_strobe && w_kind == CYC_REG_WR) begin
				if (w_port_slot) begin
					ff_prim_slot <= wdata;
				end
				else if (w_port_mapper) begin
					ff_seg[addr.io.port[1:0]] <= wdata[`MSX_SEG_W-1:0];
				end
				else if (w_pri == 2'd0) begin
					ff_sub0 <= wdata;
				end
				else begin
					ff_sub3 <= wdata;
				end
			end
		end
	end

	// Cycle payload
	always_ff @(posedge clk42m) begin
		if (w_strobe) begin
			cyc.addr		<= addr;
			cyc.slot.pri	<= w_pri;
			cyc.slot.sec	<= w_sec;
			cyc.wdata		<= wdata;
			cyc.segment		<= ff_seg[w_page];		// Segment of the page, I/O ignores it
			cyc.reg_rdata	<= w_reg_rdata;
		end
	end

endmodule

//--- src/msx_map_top.sv
`timescale 1ns/100ps
`include "msx_map_settings.svh"

module msx_map_top (
	input	logic							clk42m,
	input	logic							ff_reset_n,
	// CPU bus
	input	logic [`MSX_ADDR_W-1:0]			addr,
	input	logic [`MSX_DATA_W-1:0]			wdata,
	input	logic							mreq_n,
	input	logic							iorq_n,
	input	logic							rd_n,
	input	logic							wr_n,
	output	logic [`MSX_DATA_W-1:0]			cpu_rdata,
	output	logic							cpu_wait_n,
	// SDRAM request side
	output	logic							sdram_req,
	output	logic							sdram_we,
	output	logic [`MSX_SDRAM_ADDR_W-1:0]	sdram_addr,
	output	logic [`MSX_DATA_W-1:0]			sdram_wdata,
	input	logic							sdram_ack,
	input	logic [`MSX_DATA_W-1:0]			sdram_rdata
);
	logic						mem_load;		// SDRAM read byte ready
	logic [`MSX_DATA_W-1:0]		mem_rdata;

	bus_cycle_if cyc ();

	// --------------------------------------------------------------------
	// Slot, subslot and mapper registers
	// --------------------------------------------------------------------
	slot_decode u_slot_decode (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.addr			( addr			),
		.wdata			( wdata			),
		.mreq_n			( mreq_n		),
		.iorq_n			( iorq_n		),
		.rd_n			( rd_n			),
		.wr_n			( wr_n			),
		.cyc			( cyc.decode	)
	);

	// --------------------------------------------------------------------
	// Region map and SDRAM handshake
	// --------------------------------------------------------------------
	sdram_map u_sdram_map (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.cyc			( cyc.user		),
		.sdram_ack		( sdram_ack		),
		.sdram_rdata	( sdram_rdata	),
		.sdram_req		( sdram_req		),
		.sdram_we		( sdram_we		),
		.sdram_addr		( sdram_addr	),
		.sdram_wdata	( sdram_wdata	),
		.cpu_wait_n		( cpu_wait_n	),
		.mem_load		( mem_load		),
		.mem_rdata		( mem_rdata		)
	);

	// CPU data latch
	read_mux u_read_mux (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.cyc			( cyc.user		),
		.rd_n			( rd_n			),
		.mem_load		( mem_load		),
		.mem_rdata		( mem_rdata		),
		.cpu_rdata		( cpu_rdata		)
	);

endmodule

//--- src/read_mux.sv
`timescale 1ns/100ps

module read_mux
	import msx_map_pkg::*;
(
	input	logic				clk42m,
	input	logic				ff_reset_n,
	bus_cycle_if.user			cyc,
	input	logic				rd_n,
	input	logic				mem_load,		// SDRAM byte arrived
	input	msx_byte_t			mem_rdata,
	output	msx_byte_t			cpu_rdata
);
	logic	w_reg_load;

	// Register readback comes straight with the decoded cycle
	assign w_reg_load = cyc.valid && (cyc.kind == CYC_REG_RD);

	// --------------------------------------------------------------------
	// CPU data latch
	// --------------------------------------------------------------------
	// Open bus reads as FFh, unmapped memory never loads
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			cpu_rdata <= '1;
		end
		else if (mem_load) begin
			cpu_rdata <= mem_rdata;
		end
		else if (w_reg_load) begin
			cpu_rdata <= cyc.reg_rdata;
		end
		else if (rd_n) begin
			cpu_rdata <= '1;		// Bus released
		end
		else begin
			// Hold while rd_n is low
		end
	end

endmodule

//--- src/sdram_map.sv
`timescale 1ns/100ps
`include "msx_map_settings.svh"

module sdram_map
	import msx_map_pkg::*;
(
	input	logic				clk42m,
	input	logic				ff_reset_n,
	bus_cycle_if.user			cyc,
	input	logic				sdram_ack,
	input	msx_byte_t			sdram_rdata,
	output	logic				sdram_req,
	output	logic				sdram_we,
	output	sdram_addr_t		sdram_addr,
	output	msx_byte_t			sdram_wdata,
	output	logic				cpu_wait_n,
	output	logic				mem_load,
	output	msx_byte_t			mem_rdata
);
	typedef enum logic [1:0] {
		ST_IDLE		= 2'd0,
		ST_REQ		= 2'd1,		// req high, waiting for ack
		ST_RELEASE	= 2'd2		// req low, waiting for ack to drop
	} state_e;

	state_e								ff_state;
	logic								ff_pend;		// Cycle queued behind ack release
	logic [`MSX_ADDR_W-1:0]				w_a;
	logic [`MSX_SDRAM_ADDR_W-14:0]		w_upper;		// SDRAM bits 22:13
	logic								w_hit;
	logic								w_is_wr;
	logic								w_load;

	assign w_a		= cyc.addr;
	assign w_is_wr	= (cyc.kind == CYC_MEM_WR);

	// --------------------------------------------------------------------
	// Region map
	// --------------------------------------------------------------------
	always_comb begin
		w_hit	= 1'b1;
		w_upper	= '0;
		if (cyc.slot == {2'd3, 2'd0}) begin
			w_upper = {1'b1, cyc.segment, w_a[13]};				// Mapper RAM
		end
		else if (w_is_wr) begin
			w_hit = 1'b0;										// All other regions are ROM
		end
		else begin
			case (cyc.slot)
			{2'd0, 2'd3}: begin		// Logo, ext BASIC
				w_hit	= (w_a[15:14] == 2'b01) || (w_a[15:14] == 2'b10);
				w_upper	= {8'b0000_0111, w_a[14:13]};
			end
			{2'd0, 2'd2}: begin		// MSX-MUSIC
				w_hit	= (w_a[15:14] == 2'b01);
				w_upper	= {9'b0_0000_0110, w_a[13]};
			end
			{2'd0, 2'd1}: begin
				w_hit	= (w_a[15:14] == 2'b01);
				w_upper	= {9'b0_0000_0100, w_a[13]};
			end
			{2'd3, 2'd1}: begin		// Sub-ROM in page 0, kanji BASIC above
				w_upper	= (w_a[15:14] == 2'b00) ? {1'b0, 8'b0001_0000, w_a[13]} :
												  {8'b0000_0101, w_a[15], w_a[13]};
			end
			{2'd0, 2'd0}: begin		// Main ROM, 32KB
				w_hit	= !w_a[15];
				w_upper	= {8'b0000_0100, w_a[14:13]};
			end
			{2'd3, 2'd2}: begin		// Disk ROM banks
				w_hit	= (w_a[15:14] == 2'b01) || (w_a[15:14] == 2'b10);
				w_upper	= {7'b000_0000, w_a[15:13]};
			end
			default: w_hit = 1'b0;	// 3-3 and slots 1, 2
			endcase
		end
	end

	// New mapped memory cycle, never while req is up
	assign w_load = cyc.valid && (cyc.kind == CYC_MEM_RD || w_is_wr) && w_hit &&
					(ff_state != ST_REQ);

	// --------------------------------------------------------------------
	// Four-phase request and CPU wait
	// --------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_state	<= ST_IDLE;
			ff_pend		<= 1'b0;
			sdram_req	<= 1'b0;
			cpu_wait_n	<= 1'b1;
			mem_load	<= 1'b0;
		end
		else begin
			mem_load <= 1'b0;
			if (w_load) begin
				cpu_wait_n <= 1'b0;
			end
			case (ff_state)
			ST_IDLE: begin
				if (w_load) begin
					sdram_req	<= 1'b1;
					ff_state	<= ST_REQ;
				end
			end
			ST_REQ: begin
				if (sdram_ack) begin
					sdram_req	<= 1'b0;
					cpu_wait_n	<= 1'b1;
					mem_load	<= !sdram_we;		// Reads only
					ff_state	<= ST_RELEASE;
				end
			end
			default: begin
				if (!sdram_ack) begin
					if (ff_pend || w_load) begin
						sdram_req	<= 1'b1;
						ff_state	<= ST_REQ;
					end
					else begin
						ff_state	<= ST_IDLE;
					end
					ff_pend <= 1'b0;
				end
				else if (w_load) begin
					ff_pend <= 1'b1;
				end
			end
			endcase
		end
	end

	// Request payload, stable while req is high
	always_ff @(posedge clk42m) begin
		if (w_load) begin
			sdram_addr	<= {w_upper, w_a[12:0]};
			sdram_we	<= w_is_wr;
			sdram_wdata	<= cyc.wdata;
		end
		if (ff_state == ST_REQ && sdram_ack) begin
			mem_rdata <= sdram_rdata;
		end
	end

endmodule

//--- verilog.f
+incdir+common
common/msx_map_pkg.sv
common/bus_cycle_if.sv
slot_decode/slot_decode.sv
src/sdram_map.sv
src/read_mux.sv
src/msx_map_top.sv
sim/msx_map_checker.sv
sim/msx_map_tb.sv
